/* common/wb_defines.svh */
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// datapath and field widths
`define DATA_W          32
`define GPR_ADDR_W      5
`define CSR_NUM_W       14
`define ECODE_W         6
`define ESUBCODE_W      9
`define EXCP_NUM_W      9

// bit positions inside the one-hot exception vector
`define EXCP_INT        0
`define EXCP_SYS        5
`define EXCP_BRK        6
`define EXCP_INE        7
`define EXCP_IPE        8

// exception codes as written to estat.ecode
`define ECODE_INT       6'h00
`define ECODE_SYS       6'h0b
`define ECODE_BRK       6'h0c
`define ECODE_INE       6'h0d
`define ECODE_IPE       6'h0e

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_EENTRY      14'h00c

// exception entry after reset, 64 byte aligned
`define EENTRY_RESET    32'h1c00_8000

`endif

/* common/wb_pkg.sv */
`include "wb_defines.svh"

package wb_pkg;

    // one retiring instruction as handed over by the memory stage
    typedef struct packed {
        logic [`DATA_W-1:0]      pc;
        logic [`DATA_W-1:0]      inst;
        logic [`DATA_W-1:0]      result;
        logic                    wreg_en;
        logic [`GPR_ADDR_W-1:0]  wreg_index;
        // one-hot, int adef tlbr pif ppi syscall brk ine ipe
        logic [`EXCP_NUM_W-1:0]  excp_num;
        logic                    ertn;
        logic                    csr_we;
        logic [`CSR_NUM_W-1:0]   csr_num;
        logic [`DATA_W-1:0]      csr_wdata;
    } mem_wb_t;

    // commit request toward the csr unit
    typedef struct packed {
        logic                    excp;
        logic                    ertn;
        logic [`ECODE_W-1:0]     ecode;
        logic [`ESUBCODE_W-1:0]  esubcode;
        logic [`DATA_W-1:0]      era;
        logic                    csr_we;
        logic [`CSR_NUM_W-1:0]   csr_num;
        logic [`DATA_W-1:0]      csr_wdata;
    } csr_req_t;

    // forwarding bundle for earlier stages
    typedef struct packed {
        logic                    we;
        logic [`GPR_ADDR_W-1:0]  index;
        logic [`DATA_W-1:0]      data;
    } bypass_t;

    // implemented csrs
    typedef enum logic [`CSR_NUM_W-1:0] {
        CSR_IDX_CRMD   = `CSR_CRMD,
        CSR_IDX_PRMD   = `CSR_PRMD,
        CSR_IDX_ESTAT  = `CSR_ESTAT,
        CSR_IDX_ERA    = `CSR_ERA,
        CSR_IDX_EENTRY = `CSR_EENTRY
    } csr_index_e;

endpackage

/* common/stage_if.sv */
`timescale 1ns/10ps

// valid/ready link between two pipeline stages
interface stage_if #(
    parameter type payload_t = logic [31:0]
) ();

    // source side
    logic     valid;
    payload_t payload;

    // sink side
    logic     ready;

    // transfer on a rising edge with both valid and ready high
    // payload held by the source until that edge

    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

    // passive view for checkers
    modport monitor (
        input valid,
        input payload,
        input ready
    );

endinterface

/* hw/mem_wb_buffer.sv */
`timescale 1ns/10ps

module mem_wb_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    stage_if.sink  up,
    stage_if.source down
);

    logic     valid_q;
    payload_t data_q;
    logic     up_fire;
    logic     down_fire;

    // accept when empty or when the held entry leaves this cycle
    assign up.ready = !valid_q || down.ready;

    assign up_fire   = up.valid && up.ready;
    assign down_fire = valid_q && down.ready;

    // occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (up_fire && !flush) begin
            valid_q <= 1'b1;
        end else if (down_fire) begin
            valid_q <= 1'b0;
        end
    end

    // payload only, no reset
    always_ff @(posedge clk) begin
        if (up_fire && !flush) begin
            data_q <= up.payload;
        end
    end

    assign down.valid   = valid_q;
    assign down.payload = data_q;

    // stalled offer from the memory stage must hold until accepted
    a_stable_while_stalled: assert property (
        @(posedge clk) disable iff (!arst_n)
        up.valid && !up.ready |=> up.valid && $stable(up.payload)
    );

endmodule

/* wb/wb_stage.sv */
`timescale 1ns/10ps
`include "wb_defines.svh"

module wb_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    stage_if.sink                    up,
    input  logic                     retire_ready,
    input  logic [`DATA_W-1:0]       flush_target,
    output logic                     retire_valid,
    output logic [`DATA_W-1:0]       retire_pc,
    output logic [`DATA_W-1:0]       retire_inst,
    output logic                     flush,
    output wb_pkg::csr_req_t         csr_req,
    output logic                     commit,
    output logic                     rf_we,
    output logic [`GPR_ADDR_W-1:0]   rf_waddr,
    output logic [`DATA_W-1:0]       rf_wdata,
    output wb_pkg::bypass_t          bypass
);

    import wb_pkg::*;

    mem_wb_t                 entry;
    logic                    has_excp;
    logic [`ECODE_W-1:0]     ecode;

    assign entry = up.payload;

    // handshake toward retire
    assign up.ready     = retire_ready;
    assign retire_valid = up.valid;
    assign commit       = up.valid && retire_ready;
    assign retire_pc    = entry.pc;
    assign retire_inst  = entry.inst;

    assign has_excp = |entry.excp_num;

    // fixed priority, int first
    // tlb and adef bits fall through to code zero
    always_comb begin
        if (entry.excp_num[`EXCP_INT]) begin
            ecode = `ECODE_INT;
        end else if (entry.excp_num[`EXCP_SYS]) begin
            ecode = `ECODE_SYS;
        end else if (entry.excp_num[`EXCP_BRK]) begin
            ecode = `ECODE_BRK;
        end else if (entry.excp_num[`EXCP_INE]) begin
            ecode = `ECODE_INE;
        end else if (entry.excp_num[`EXCP_IPE]) begin
            ecode = `ECODE_IPE;
        end else begin
            ecode = '0;
        end
    end

    // redirect the front end on exception or return
    assign flush = commit && (has_excp || entry.ertn);

    // csr side, write dropped if the instruction traps
    assign csr_req.excp      = has_excp;
    assign csr_req.ertn      = entry.ertn;
    assign csr_req.ecode     = ecode;
    // no implemented cause has a subcode
    assign csr_req.esubcode  = '0;
    assign csr_req.era       = entry.pc;
    assign csr_req.csr_we    = entry.csr_we && !has_excp;
    assign csr_req.csr_num   = entry.csr_num;
    assign csr_req.csr_wdata = entry.csr_wdata;

    // gpr write only on a clean commit
    assign rf_we    = commit && entry.wreg_en && !has_excp;
    assign rf_waddr = entry.wreg_index;
    assign rf_wdata = entry.result;

    // forwarding follows the held entry, not the commit
    assign bypass.we    = up.valid && entry.wreg_en && !has_excp;
    assign bypass.index = entry.wreg_index;
    assign bypass.data  = entry.result;

    // memory stage never tags one instruction as both trap and return
    a_excp_ertn_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit |-> !(has_excp && entry.ertn)
    );

    // csr unit must hand back a defined target whenever we redirect
    a_flush_target_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |-> !$isunknown(flush_target)
    );

endmodule

/* wb/csr_excp_unit.sv */
`timescale 1ns/10ps
`include "wb_defines.svh"

module csr_excp_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    commit,
    input  wb_pkg::csr_req_t        csr_req,
    input  logic [`CSR_NUM_W-1:0]   dbg_csr_num,
    output logic [`DATA_W-1:0]      flush_target,
    output logic [`DATA_W-1:0]      dbg_csr_data
);

    import wb_pkg::*;

    // crmd, only plv and ie kept
    logic [1:0]              crmd_plv;
    logic                    crmd_ie;
    // prmd, previous plv and ie
    logic [1:0]              prmd_pplv;
    logic                    prmd_pie;
    // estat, cause plus software interrupt bits
    logic [`ECODE_W-1:0]     estat_ecode;
    logic [`ESUBCODE_W-1:0]  estat_esubcode;
    logic [1:0]              estat_is;
    logic [`DATA_W-1:0]      era;
    logic [`DATA_W-1:0]      eentry;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd_plv       <= 2'd0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'd0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            estat_is       <= 2'd0;
            era            <= '0;
            eentry         <= `EENTRY_RESET;
        end else if (commit) begin
            if (csr_req.excp) begin
                // save mode, drop to kernel with interrupts off
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                crmd_plv       <= 2'd0;
                crmd_ie        <= 1'b0;
                estat_ecode    <= csr_req.ecode;
                estat_esubcode <= csr_req.esubcode;
                era            <= csr_req.era;
            end else if (csr_req.ertn) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (csr_req.csr_we) begin
                case (csr_req.csr_num)
                    CSR_IDX_CRMD: begin
                        crmd_plv <= csr_req.csr_wdata[1:0];
                        crmd_ie  <= csr_req.csr_wdata[2];
                    end
                    CSR_IDX_PRMD: begin
                        prmd_pplv <= csr_req.csr_wdata[1:0];
                        prmd_pie  <= csr_req.csr_wdata[2];
                    end
                    // cause fields are read only for software
                    CSR_IDX_ESTAT:  estat_is <= csr_req.csr_wdata[1:0];
                    CSR_IDX_ERA:    era      <= csr_req.csr_wdata;
                    // entry stays 64 byte aligned
                    CSR_IDX_EENTRY: eentry   <= {csr_req.csr_wdata[31:6], 6'b0};
                    default: ;
                endcase
            end
        end
    end

    // trap goes to eentry, return goes to era
    assign flush_target = csr_req.excp ? eentry : era;

    // observation port, shows state after the last edge
    always_comb begin
        case (dbg_csr_num)
            CSR_IDX_CRMD:   dbg_csr_data = {29'b0, crmd_ie, crmd_plv};
            CSR_IDX_PRMD:   dbg_csr_data = {29'b0, prmd_pie, prmd_pplv};
            CSR_IDX_ESTAT:  dbg_csr_data = {1'b0, estat_esubcode, estat_ecode, 14'b0, estat_is};
            CSR_IDX_ERA:    dbg_csr_data = era;
            CSR_IDX_EENTRY: dbg_csr_data = eentry;
            default:        dbg_csr_data = '0;
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps
`include "wb_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   we,
    input  logic [`GPR_ADDR_W-1:0] waddr,
    input  logic [`DATA_W-1:0]     wdata,
    input  logic [`GPR_ADDR_W-1:0] dbg_addr,
    output logic [`DATA_W-1:0]     dbg_data
);

    localparam int NUM_REGS = 1 << `GPR_ADDR_W;

    logic [`DATA_W-1:0] regs [NUM_REGS];

    // single write port, r0 never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero
    // combinational, new value visible right after the write edge
    always_comb begin
        if (dbg_addr == '0) begin
            dbg_data = '0;
        end else begin
            dbg_data = regs[dbg_addr];
        end
    end

endmodule

/* hw/wb_subsys_top.sv */
`timescale 1ns/10ps
`include "wb_defines.svh"

module wb_subsys_top (
    input  logic                    clk,
    input  logic                    arst_n,
    // memory stage side
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`DATA_W-1:0]      in_pc,
    input  logic [`DATA_W-1:0]      in_inst,
    input  logic [`DATA_W-1:0]      in_result,
    input  logic                    in_wreg_en,
    input  logic [`GPR_ADDR_W-1:0]  in_wreg_index,
    input  logic [`EXCP_NUM_W-1:0]  in_excp_num,
    input  logic                    in_ertn,
    input  logic                    in_csr_we,
    input  logic [`CSR_NUM_W-1:0]   in_csr_num,
    input  logic [`DATA_W-1:0]      in_csr_wdata,
    // retire
    output logic                    retire_valid,
    input  logic                    retire_ready,
    output logic [`DATA_W-1:0]      retire_pc,
    output logic [`DATA_W-1:0]      retire_inst,
    // redirect
    output logic                    flush,
    output logic [`DATA_W-1:0]      flush_target,
    // forwarding
    output logic                    byp_we,
    output logic [`GPR_ADDR_W-1:0]  byp_index,
    output logic [`DATA_W-1:0]      byp_data,
    // observation
    input  logic [`GPR_ADDR_W-1:0]  dbg_reg_addr,
    output logic [`DATA_W-1:0]      dbg_reg_data,
    input  logic [`CSR_NUM_W-1:0]   dbg_csr_num,
    output logic [`DATA_W-1:0]      dbg_csr_data
);

    import wb_pkg::*;

    stage_if #(.payload_t(mem_wb_t)) in_if ();
    stage_if #(.payload_t(mem_wb_t)) mw_if ();

    csr_req_t               csr_req;
    logic                   commit;
    logic                   rf_we;
    logic [`GPR_ADDR_W-1:0] rf_waddr;
    logic [`DATA_W-1:0]     rf_wdata;
    bypass_t                bypass;

    // pack the flat input into the pipeline payload
    assign in_if.valid   = in_valid;
    assign in_if.payload = '{pc: in_pc, inst: in_inst, result: in_result,
                             wreg_en: in_wreg_en, wreg_index: in_wreg_index,
                             excp_num: in_excp_num, ertn: in_ertn, csr_we: in_csr_we,
                             csr_num: in_csr_num, csr_wdata: in_csr_wdata};
    assign in_ready      = in_if.ready;

    mem_wb_buffer #(.payload_t(mem_wb_t)) i_buffer (
        .clk, .arst_n, .flush, .up(in_if), .down(mw_if)
    );

    wb_stage i_wb_stage (
        .clk, .arst_n, .up(mw_if), .retire_ready, .flush_target,
        .retire_valid, .retire_pc, .retire_inst, .flush, .csr_req, .commit,
        .rf_we, .rf_waddr, .rf_wdata, .bypass
    );

    csr_excp_unit i_csr (
        .clk, .arst_n, .commit, .csr_req, .dbg_csr_num, .flush_target, .dbg_csr_data
    );

    reg_file i_reg_file (
        .clk, .arst_n, .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .dbg_addr(dbg_reg_addr), .dbg_data(dbg_reg_data)
    );

    // unpack forwarding bundle
    assign byp_we    = bypass.we;
    assign byp_index = bypass.index;
    assign byp_data  = bypass.data;

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

// free running clock plus a reset held for a few cycles
module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release a little after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

/* test/tb_wb_subsys.sv */
`timescale 1ns/10ps
`include "wb_defines.svh"

module tb_wb_subsys;

    import wb_pkg::*;

    localparam int N_RANDOM = 200;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic                    in_ready;
    logic [`DATA_W-1:0]      in_pc;
    logic [`DATA_W-1:0]      in_inst;
    logic [`DATA_W-1:0]      in_result;
    logic                    in_wreg_en;
    logic [`GPR_ADDR_W-1:0]  in_wreg_index;
    logic [`EXCP_NUM_W-1:0]  in_excp_num;
    logic                    in_ertn;
    logic                    in_csr_we;
    logic [`CSR_NUM_W-1:0]   in_csr_num;
    logic [`DATA_W-1:0]      in_csr_wdata;
    logic                    retire_valid;
    logic                    retire_ready;
    logic [`DATA_W-1:0]      retire_pc;
    logic [`DATA_W-1:0]      retire_inst;
    logic                    flush;
    logic [`DATA_W-1:0]      flush_target;
    logic                    byp_we;
    logic [`GPR_ADDR_W-1:0]  byp_index;
    logic [`DATA_W-1:0]      byp_data;
    logic [`GPR_ADDR_W-1:0]  dbg_reg_addr;
    logic [`DATA_W-1:0]      dbg_reg_data;
    logic [`CSR_NUM_W-1:0]   dbg_csr_num;
    logic [`DATA_W-1:0]      dbg_csr_data;

    // stimulus, accepted but not yet retired, pending debug reads
    mem_wb_t               stim_q[$];
    mem_wb_t               exp_q[$];
    logic [`GPR_ADDR_W-1:0] reg_rd_q[$];
    logic [`CSR_NUM_W-1:0]  csr_rd_q[$];
    logic [`CSR_NUM_W-1:0]  csr_list [6] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT,
                                            `CSR_ERA, `CSR_EENTRY, 14'h020};
    logic [`DATA_W-1:0]    next_pc = 32'h1c00_0000;
    int                    n_directed;
    bit                    random_phase;
    bit                    issue_done;
    int                    err_count;
    int                    dropped;
    int                    retired;
    int                    cycle_count;
    int                    cycle_limit;

    // reference state, crmd and prmd as {ie, plv}
    logic [`DATA_W-1:0]     m_regs [32];
    logic [2:0]             m_crmd;
    logic [2:0]             m_prmd;
    logic [`ECODE_W-1:0]    m_ecode;
    logic [`ESUBCODE_W-1:0] m_esubcode;
    logic [1:0]             m_is;
    logic [`DATA_W-1:0]     m_era;
    logic [`DATA_W-1:0]     m_eentry;

    tb_clock #(.PERIOD_NS(40), .RST_CYCLES(3)) i_clock (.clk, .arst_n);

    wb_subsys_top i_dut (.*);

    // highest priority cause wins, tlb and adef give zero
    function automatic logic [`ECODE_W-1:0] expected_ecode(input logic [`EXCP_NUM_W-1:0] bits);
        if (bits[`EXCP_INT]) return `ECODE_INT;
        if (bits[`EXCP_SYS]) return `ECODE_SYS;
        if (bits[`EXCP_BRK]) return `ECODE_BRK;
        if (bits[`EXCP_INE]) return `ECODE_INE;
        if (bits[`EXCP_IPE]) return `ECODE_IPE;
        return '0;
    endfunction

    function automatic logic [`DATA_W-1:0] model_csr(input logic [`CSR_NUM_W-1:0] num);
        case (num)
            `CSR_CRMD:   return {29'b0, m_crmd};
            `CSR_PRMD:   return {29'b0, m_prmd};
            `CSR_ESTAT:  return {1'b0, m_esubcode, m_ecode, 14'b0, m_is};
            `CSR_ERA:    return m_era;
            `CSR_EENTRY: return m_eentry;
            default:     return '0;
        endcase
    endfunction

    // architectural effect of one committed instruction
    function automatic void model_commit(input mem_wb_t it);
        logic trap;
        trap = |it.excp_num;
        if (trap) begin
            m_prmd     = m_crmd;
            m_crmd     = 3'b0;
            m_ecode    = expected_ecode(it.excp_num);
            m_esubcode = '0;
            m_era      = it.pc;
        end else begin
            if (it.wreg_en && it.wreg_index != 5'd0) begin
                m_regs[it.wreg_index] = it.result;
            end
            if (it.ertn) begin
                m_crmd = m_prmd;
            end else if (it.csr_we) begin
                case (it.csr_num)
                    `CSR_CRMD:   m_crmd   = it.csr_wdata[2:0];
                    `CSR_PRMD:   m_prmd   = it.csr_wdata[2:0];
                    // only the software interrupt bits are writable
                    `CSR_ESTAT:  m_is     = it.csr_wdata[1:0];
                    `CSR_ERA:    m_era    = it.csr_wdata;
                    `CSR_EENTRY: m_eentry = {it.csr_wdata[31:6], 6'b0};
                    default: ;
                endcase
            end
        end
    endfunction

    function automatic mem_wb_t alu_op(input logic [4:0] idx, input logic [31:0] value);
        mem_wb_t it;
        it            = '0;
        it.wreg_en    = 1'b1;
        it.wreg_index = idx;
        it.result     = value;
        return it;
    endfunction

    function automatic mem_wb_t csr_write(input logic [13:0] num, input logic [31:0] value);
        mem_wb_t it;
        it           = '0;
        it.csr_we    = 1'b1;
        it.csr_num   = num;
        it.csr_wdata = value;
        return it;
    endfunction

    function automatic mem_wb_t trap_op(input logic [`EXCP_NUM_W-1:0] bits);
        mem_wb_t it;
        it          = '0;
        it.excp_num = bits;
        return it;
    endfunction

    function automatic mem_wb_t ertn_op();
        mem_wb_t it;
        it      = '0;
        it.ertn = 1'b1;
        return it;
    endfunction

    // unique pc per item so a lost or dropped entry shows up at once
    task automatic push_stim(input mem_wb_t it);
        it.pc   = next_pc;
        it.inst = $urandom;
        next_pc = next_pc + 32'd4;
        stim_q.push_back(it);
    endtask

    task automatic build_directed();
        mem_wb_t it;
        push_stim(csr_write(`CSR_CRMD, 32'h7));
        push_stim(csr_write(`CSR_EENTRY, 32'h1c00_1234));
        push_stim(alu_op(5'd1, 32'h1111_0001));
        push_stim(alu_op(5'd2, 32'h2222_0002));
        push_stim(alu_op(5'd0, 32'hdead_beef));
        // syscall that also tries a gpr and a csr write
        it            = trap_op(9'h020);
        it.wreg_en    = 1'b1;
        it.wreg_index = 5'd3;
        it.result     = 32'h3333_0003;
        it.csr_we     = 1'b1;
        it.csr_num    = `CSR_ERA;
        it.csr_wdata  = 32'hffff_fff0;
        push_stim(it);
        push_stim(alu_op(5'd4, 32'h4444_0004));
        push_stim(ertn_op());
        // brk with ine, int with ipe, adef alone
        push_stim(trap_op(9'h0c0));
        push_stim(trap_op(9'h101));
        push_stim(trap_op(9'h002));
        it           = trap_op(9'h080);
        it.csr_we    = 1'b1;
        it.csr_num   = `CSR_CRMD;
        it.csr_wdata = 32'h3;
        push_stim(it);
        push_stim(trap_op(9'h100));
        push_stim(csr_write(`CSR_ERA, 32'h8000_0040));
        push_stim(csr_write(`CSR_PRMD, 32'h5));
        push_stim(ertn_op());
        push_stim(csr_write(`CSR_ESTAT, 32'hffff_ffff));
        push_stim(csr_write(14'h020, 32'h1234_5678));
    endtask

    task automatic build_random();
        mem_wb_t     it;
        logic [31:0] rnd;
        int          pick;
        int          sel;
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd  = $urandom;
            pick = $urandom % 100;
            sel  = $urandom % 6;
            it   = alu_op(rnd[4:0], $urandom);
            it.wreg_en = rnd[5] | rnd[6];
            if (pick < 8) begin
                // any nonzero mix of causes, writes must vanish
                it.excp_num = rnd[16:8];
                if (it.excp_num == '0) begin
                    it.excp_num = 9'h020;
                end
                it.csr_we    = rnd[7];
                it.csr_num   = csr_list[sel];
                it.csr_wdata = $urandom;
            end else if (pick < 13) begin
                it = ertn_op();
            end else if (pick < 28) begin
                it.csr_we    = 1'b1;
                it.csr_num   = csr_list[sel];
                it.csr_wdata = $urandom;
            end
            push_stim(it);
        end
    endtask

    task automatic drive_item(input mem_wb_t it);
        in_pc         = it.pc;
        in_inst       = it.inst;
        in_result     = it.result;
        in_wreg_en    = it.wreg_en;
        in_wreg_index = it.wreg_index;
        in_excp_num   = it.excp_num;
        in_ertn       = it.ertn;
        in_csr_we     = it.csr_we;
        in_csr_num    = it.csr_num;
        in_csr_wdata  = it.csr_wdata;
        in_valid      = 1'b1;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("[FAIL] t=%0.1f ns %s expected %08h actual %08h",
                 $realtime, name, expected, actual);
        $display("Something failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string what);
        err_count++;
        $display("error at t=%0.1f ns: %s", $realtime, what);
        $display("Something failed");
        $fatal(1, "stopped on error");
    endtask

    // run length bound
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no end of test after %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // consumer side, always ready outside the random part
    always @(posedge clk) begin
        #2;
        if (random_phase) begin
            retire_ready = ($urandom % 3) != 0;
        end else begin
            retire_ready = 1'b1;
        end
    end

    // producer side
    initial begin : issue
        mem_wb_t it;
        wait (arst_n === 1'b1);
        @(posedge clk);
        foreach (stim_q[i]) begin
            it           = stim_q[i];
            random_phase = (i >= n_directed);
            if (random_phase && ($urandom % 4 == 0)) begin
                #2;
                in_valid = 1'b0;
                @(posedge clk);
            end
            #2;
            drive_item(it);
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            // transfer during a redirect is thrown away
            if (flush) begin
                dropped++;
            end else begin
                exp_q.push_back(it);
            end
            @(posedge clk);
            // directed part keeps the next item out of the flush cycle
            if (!random_phase && ((|it.excp_num) || it.ertn)) begin
                #2;
                in_valid = 1'b0;
                repeat (2) @(posedge clk);
            end
        end
        #2;
        in_valid   = 1'b0;
        issue_done = 1'b1;
    end

    // comparator, decides at mid cycle what the next edge commits
    initial begin : compare
        mem_wb_t     head;
        logic        commit_pending;
        logic        trap;
        logic [31:0] rnd;
        int          rot;
        commit_pending = 1'b0;
        rot            = 0;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (commit_pending) begin
                model_commit(head);
                commit_pending = 1'b0;
            end
            #2;
            if (reg_rd_q.size() > 0) begin
                dbg_reg_addr = reg_rd_q.pop_front();
            end else begin
                rnd          = $urandom;
                dbg_reg_addr = rnd[4:0];
            end
            if (csr_rd_q.size() > 0) begin
                dbg_csr_num = csr_rd_q.pop_front();
            end else begin
                dbg_csr_num = csr_list[rot];
                rot         = (rot + 1) % 6;
            end
            @(negedge clk);
            expect_equal("dbg_reg_data", m_regs[dbg_reg_addr], dbg_reg_data);
            expect_equal("dbg_csr_data", model_csr(dbg_csr_num), dbg_csr_data);
            // buffer takes a new item when empty or when its entry retires now
            expect_equal("in_ready", {31'b0, !retire_valid || retire_ready},
                         {31'b0, in_ready});
            if (retire_valid) begin
                assert (exp_q.size() > 0) else abort_run("retire_valid with nothing accepted");
                head = exp_q[0];
                trap = |head.excp_num;
                expect_equal("retire_pc", head.pc, retire_pc);
                expect_equal("retire_inst", head.inst, retire_inst);
                expect_equal("byp_we", {31'b0, head.wreg_en && !trap}, {31'b0, byp_we});
                if (byp_we) begin
                    expect_equal("byp_index", {27'b0, head.wreg_index}, {27'b0, byp_index});
                    expect_equal("byp_data", head.result, byp_data);
                end
                if (retire_ready) begin
                    expect_equal("flush", {31'b0, trap || head.ertn}, {31'b0, flush});
                    if (trap) begin
                        expect_equal("flush_target", m_eentry, flush_target);
                        csr_rd_q.push_back(`CSR_ERA);
                        csr_rd_q.push_back(`CSR_ESTAT);
                        csr_rd_q.push_back(`CSR_PRMD);
                    end else if (head.ertn) begin
                        expect_equal("flush_target", m_era, flush_target);
                        csr_rd_q.push_back(`CSR_CRMD);
                    end else if (head.csr_we) begin
                        csr_rd_q.push_back(head.csr_num);
                    end
                    if (head.wreg_en) begin
                        reg_rd_q.push_back(head.wreg_index);
                    end
                    head           = exp_q.pop_front();
                    commit_pending = 1'b1;
                    retired++;
                end else begin
                    expect_equal("flush", 32'b0, {31'b0, flush});
                end
            end else begin
                expect_equal("byp_we", 32'b0, {31'b0, byp_we});
                expect_equal("flush", 32'b0, {31'b0, flush});
            end
        end
    end

    initial begin : main
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_result     = '0;
        in_wreg_en    = 1'b0;
        in_wreg_index = '0;
        in_excp_num   = '0;
        in_ertn       = 1'b0;
        in_csr_we     = 1'b0;
        in_csr_num    = '0;
        in_csr_wdata  = '0;
        retire_ready  = 1'b0;
        dbg_reg_addr  = '0;
        dbg_csr_num   = `CSR_CRMD;
        foreach (m_regs[r]) begin
            m_regs[r] = '0;
        end
        m_crmd     = 3'b0;
        m_prmd     = 3'b0;
        m_ecode    = '0;
        m_esubcode = '0;
        m_is       = 2'b0;
        m_era      = '0;
        m_eentry   = `EENTRY_RESET;
        void'($urandom(32'hbece));
        build_directed();
        n_directed = stim_q.size();
        build_random();
        cycle_limit = 20 * stim_q.size() + 100;
        wait (arst_n === 1'b1);
        while (!(issue_done && exp_q.size() == 0)) begin
            @(posedge clk);
        end
        // final sweep of every register and csr
        for (int i = 0; i < 32; i++) begin
            reg_rd_q.push_back(5'(i));
        end
        foreach (csr_list[c]) begin
            csr_rd_q.push_back(csr_list[c]);
        end
        while (reg_rd_q.size() > 0 || csr_rd_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        expect_equal("retire_valid", 32'b0, {31'b0, retire_valid});
        $display("issued %0d, retired %0d, dropped in flush %0d",
                 stim_q.size(), retired, dropped);
        if (err_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "errors seen");
        end
    end

endmodule

/* wb_subsys_top.f */
+incdir+common
common/wb_pkg.sv
common/stage_if.sv
hw/mem_wb_buffer.sv
wb/wb_stage.sv
wb/csr_excp_unit.sv
hw/reg_file.sv
hw/wb_subsys_top.sv
test/tb_clock.sv
test/tb_wb_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the write-back subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_wb_subsys

verilator --binary --timing --assert -f wb_subsys_top.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
